// ==== sim/bus_stim.txt ====
// op addr lanes data expect resp, op: 0 write 1 read 2 set switches 3 check LEDs F end
// lanes: 2 upper 1 lower; resp: edges from strobe to response, plus 10 for a bus error
3 00000000 0 0000 0000 00
0 FF400000 3 1111 0000 04
0 FF400010 3 2222 0000 04
0 FF4007FE 3 ABCD 0000 04
1 FF400000 3 0000 1111 04
1 FF4007FE 3 0000 ABCD 04
1 FF400800 3 0000 1111 04
0 FF400010 2 9900 0000 04
1 FF400010 3 0000 9922 04
0 FF400000 1 00EE 0000 04
1 FF400000 3 0000 11EE 04
0 FFDC0600 3 12A5 0000 02
0 FFDC0600 2 FF3C 0000 02
3 00000000 0 00A5 0000 00
2 00000000 0 006B 0000 00
1 FFDC0602 3 0000 006B 02
0 FFDC0C00 3 1234 0000 02
0 FFDC0C02 3 0000 0000 02
0 FFDC0C00 3 0000 0000 02
1 FFDC0C00 3 0000 0001 02
0 FFDC0C02 3 ACE1 0000 02
0 FFDC0C00 3 2469 0000 02
0 FFDC0C04 3 0000 0000 02
0 FFDC0C04 3 0000 0000 02
0 FFDC0C04 3 0000 0000 02
1 FFDC0C00 3 0000 248C 02
1 FFDC0C02 3 0000 7584 02
0 FF000000 3 DEAD 0000 11
0 FFDC0700 1 0077 0000 11
1 FF400000 3 0000 11EE 04
3 00000000 0 00A5 0000 00
F 00000000 0 0000 0000 00

// ==== compile.f ====
+incdir+rtl
rtl/m68k_bus_pkg.sv
rtl/wait_state_counter.sv
rtl/stack_ram.sv
rtl/lfsr_random.sv
rtl/led_switch_port.sv
rtl/bus_cycle_ctrl.sv
rtl/m68k_sys_bus.sv
sim/tb_m68k_sys_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
: > sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_m68k_sys_bus -Mdir obj_dir -o tb_m68k_sys_bus \
	-f compile.f \
	&& ./obj_dir/tb_m68k_sys_bus > sim.log 2>&1 \
	|| echo "Verilator build or simulation returned an error"
cat sim.log
grep -q "^Simulation PASSED$" sim.log && exit 0 || exit 1

// ==== sim/tb_m68k_sys_bus.sv ====
// Run from the project root so sim/bus_stim.txt is found; the master keeps one bus cycle in flight
`timescale 1ns/10ps

module tb_m68k_sys_bus;
	import m68k_bus_pkg::*;

	localparam int MAX_LINES = 64;
	localparam int FIELDS    = 6;

	logic        cpu_clk;
	logic        rst_n_i;
	logic        as_n_i;
	logic        uds_n_i;
	logic        lds_n_i;
	logic        rw_i;
	bus_addr_t   addr_i;
	bus_data_t   wdata_i;
	logic [7:0]  sw_i;
	bus_data_t   rdata_o;
	logic        dtack_n_o;
	logic        berr_n_o;
	logic [7:0]  led_o;

	logic [31:0] stim [0:MAX_LINES*FIELDS-1];
	int          n_lines;
	int          cycles = 0;
	int          cycle_limit = 16 + 12 * MAX_LINES + 64;

	m68k_sys_bus dut0 (
		.cpu_clk   (cpu_clk),
		.rst_n_i   (rst_n_i),
		.as_n_i    (as_n_i),
		.uds_n_i   (uds_n_i),
		.lds_n_i   (lds_n_i),
		.rw_i      (rw_i),
		.addr_i    (addr_i),
		.wdata_i   (wdata_i),
		.sw_i      (sw_i),
		.rdata_o   (rdata_o),
		.dtack_n_o (dtack_n_o),
		.berr_n_o  (berr_n_o),
		.led_o     (led_o)
	);

	initial begin
		cpu_clk = 1'b0;
		forever #5 cpu_clk = ~cpu_clk;
	end

	// Watchdog limit shrinks once the stimulus length is known
	always @(posedge cpu_clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: test did not finish within %0d cycles", cycle_limit);
			$display("Simulation FAILED");
			$fatal(1, "watchdog stopped the run");
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// ====================================================================
	// Bus master
	// ====================================================================

	// Low nibble of resp counts edges to the response and bit 4 marks a bus error
	task automatic run_bus_cycle(input logic rd, input logic [31:0] addr,
			input logic [1:0] lanes, input logic [15:0] data,
			input logic [15:0] exp_rd, input logic [7:0] resp);
		int edges;
		int idle;
		idle = int'($urandom % 4);
		repeat (idle) @(posedge cpu_clk);
		@(posedge cpu_clk);
		addr_i  <= addr;
		rw_i    <= rd;
		wdata_i <= data;
		uds_n_i <= !lanes[1];
		lds_n_i <= !lanes[0];
		as_n_i  <= 1'b0;
		// Edge where the controller first sees the strobe
		@(posedge cpu_clk);
		edges = 0;
		@(negedge cpu_clk);
		while (dtack_n_o && berr_n_o) begin
			@(posedge cpu_clk);
			edges++;
			@(negedge cpu_clk);
		end
		check_value("response_edges", 32'(edges), {28'b0, resp[3:0]});
		check_value("berr_n_o", {31'b0, berr_n_o}, {31'b0, !resp[4]});
		check_value("dtack_n_o", {31'b0, dtack_n_o}, {31'b0, resp[4]});
		if (rd && !resp[4])
			check_value("rdata_o", {16'b0, rdata_o}, {16'b0, exp_rd});
		@(posedge cpu_clk);
		as_n_i  <= 1'b1;
		uds_n_i <= 1'b1;
		lds_n_i <= 1'b1;
		// Response must clear before the next cycle starts
		@(negedge cpu_clk);
		while (!dtack_n_o || !berr_n_o)
			@(negedge cpu_clk);
	endtask

	task automatic set_switches(input logic [7:0] value);
		@(posedge cpu_clk);
		sw_i <= value;
	endtask

	task automatic check_leds(input logic [7:0] value);
		@(negedge cpu_clk);
		check_value("led_o", {24'b0, led_o}, {24'b0, value});
	endtask

	// ====================================================================
	// Main sequence
	// ====================================================================
	initial begin
		int          base;
		logic [3:0]  op;
		void'($urandom(32'h046f_8330));
		rst_n_i = 1'b0;
		as_n_i  = 1'b1;
		uds_n_i = 1'b1;
		lds_n_i = 1'b1;
		rw_i    = 1'b1;
		addr_i  = '0;
		wdata_i = '0;
		sw_i    = '0;
		for (int i = 0; i < MAX_LINES * FIELDS; i++)
			stim[i] = {i[27:0], 4'hF};
		$readmemh("sim/bus_stim.txt", stim);
		n_lines = 0;
		while (n_lines < MAX_LINES && stim[n_lines * FIELDS][3:0] != 4'hF)
			n_lines++;
		if (n_lines == 0) begin
			$display("No stimulus lines found in sim/bus_stim.txt");
			$display("Simulation FAILED");
			$fatal(1, "empty stimulus");
		end
		cycle_limit = 16 + 12 * n_lines + 64;

		repeat (16) @(posedge cpu_clk);
		rst_n_i <= 1'b1;
		// Idle bus straight out of reset
		@(negedge cpu_clk);
		check_value("dtack_n_o", {31'b0, dtack_n_o}, 32'd1);
		check_value("berr_n_o", {31'b0, berr_n_o}, 32'd1);
		check_value("led_o", {24'b0, led_o}, 32'd0);

		for (int i = 0; i < n_lines; i++) begin
			base = i * FIELDS;
			op   = stim[base][3:0];
			case (op)
				4'h0: run_bus_cycle(1'b0, stim[base+1], stim[base+2][1:0],
					stim[base+3][15:0], stim[base+4][15:0], stim[base+5][7:0]);
				4'h1: run_bus_cycle(1'b1, stim[base+1], stim[base+2][1:0],
					stim[base+3][15:0], stim[base+4][15:0], stim[base+5][7:0]);
				4'h2: set_switches(stim[base+3][7:0]);
				4'h3: check_leds(stim[base+3][7:0]);
				default: begin
					$display("Unknown operation %h on stimulus line %0d", op, i);
					$display("Simulation FAILED");
					$fatal(1, "bad stimulus");
				end
			endcase
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== rtl/m68k_sys_bus.sv ====
// CPU-side bus only, one clock domain; interrupts are not modelled and no CPU is included
`timescale 1ns/10ps
`include "m68k_bus_settings.svh"

module m68k_sys_bus (
	input  logic                    cpu_clk,
	input  logic                    rst_n_i,
	input  logic                    as_n_i,
	input  logic                    uds_n_i,
	input  logic                    lds_n_i,
	input  logic                    rw_i,
	input  m68k_bus_pkg::bus_addr_t addr_i,
	input  m68k_bus_pkg::bus_data_t wdata_i,
	input  logic [7:0]              sw_i,
	output m68k_bus_pkg::bus_data_t rdata_o,
	output logic                    dtack_n_o,
	output logic                    berr_n_o,
	output logic [7:0]              led_o
);
	import m68k_bus_pkg::*;

	logic        cnt_load;
	wait_count_t cnt_val;
	logic        cnt_done;
	logic        stack_we;
	logic        led_we;
	logic        rand_we;
	bus_data_t   stack_rdata;
	bus_data_t   led_rdata;
	bus_data_t   rand_rdata;

	// ====================================================================
	// Cycle control
	// ====================================================================
	bus_cycle_ctrl u_ctrl (
		.cpu_clk       (cpu_clk),
		.rst_n_i       (rst_n_i),
		.as_n_i        (as_n_i),
		.uds_n_i       (uds_n_i),
		.lds_n_i       (lds_n_i),
		.rw_i          (rw_i),
		.addr_i        (addr_i),
		.stack_rdata_i (stack_rdata),
		.led_rdata_i   (led_rdata),
		.rand_rdata_i  (rand_rdata),
		.cnt_done_i    (cnt_done),
		.cnt_load_o    (cnt_load),
		.cnt_val_o     (cnt_val),
		.stack_we_o    (stack_we),
		.led_we_o      (led_we),
		.rand_we_o     (rand_we),
		.rdata_o       (rdata_o),
		.dtack_n_o     (dtack_n_o),
		.berr_n_o      (berr_n_o)
	);

	wait_state_counter u_wait (
		.cpu_clk    (cpu_clk),
		.rst_n_i    (rst_n_i),
		.load_i     (cnt_load),
		.load_val_i (cnt_val),
		.done_o     (cnt_done)
	);

	// ====================================================================
	// Targets
	// ====================================================================

	// Word address aliases inside the 1 MB window
	stack_ram u_stack (
		.cpu_clk     (cpu_clk),
		.word_addr_i (addr_i[`STACK_AW:1]),
		.we_i        (stack_we),
		.uds_n_i     (uds_n_i),
		.lds_n_i     (lds_n_i),
		.wdata_i     (wdata_i),
		.rdata_o     (stack_rdata)
	);

	led_switch_port u_led (
		.cpu_clk (cpu_clk),
		.rst_n_i (rst_n_i),
		.we_i    (led_we),
		.lds_n_i (lds_n_i),
		.wdata_i (wdata_i),
		.sw_i    (sw_i),
		.led_o   (led_o),
		.rdata_o (led_rdata)
	);

	lfsr_random u_rand (
		.cpu_clk   (cpu_clk),
		.rst_n_i   (rst_n_i),
		.we_i      (rand_we),
		.reg_sel_i (addr_i[2:1]),
		.wdata_i   (wdata_i),
		.rdata_o   (rand_rdata)
	);

endmodule

// ==== rtl/bus_cycle_ctrl.sv ====
// One bus cycle at a time; the master must hold address, rw and lanes until dtack_n_o or berr_n_o
`timescale 1ns/10ps
`include "m68k_bus_settings.svh"

module bus_cycle_ctrl (
	input  logic                     cpu_clk,
	input  logic                     rst_n_i,
	input  logic                     as_n_i,
	input  logic                     uds_n_i,
	input  logic                     lds_n_i,
	input  logic                     rw_i,
	input  m68k_bus_pkg::bus_addr_t  addr_i,
	input  m68k_bus_pkg::bus_data_t  stack_rdata_i,
	input  m68k_bus_pkg::bus_data_t  led_rdata_i,
	input  m68k_bus_pkg::bus_data_t  rand_rdata_i,
	input  logic                     cnt_done_i,
	output logic                     cnt_load_o,
	output m68k_bus_pkg::wait_count_t cnt_val_o,
	output logic                     stack_we_o,
	output logic                     led_we_o,
	output logic                     rand_we_o,
	output m68k_bus_pkg::bus_data_t  rdata_o,
	output logic                     dtack_n_o,
	output logic                     berr_n_o
);
	import m68k_bus_pkg::*;

	bus_state_e state;
	logic       strobe;
	logic       hit_stack;
	logic       hit_led;
	logic       hit_rand;
	logic       hit_any;
	logic       sel_stack;
	logic       sel_led;
	logic       sel_rand;
	logic       cyc_end;
	bus_data_t  rd_mux;

	// Strobe needs the address strobe and at least one byte lane
	assign strobe = !as_n_i && !(uds_n_i && lds_n_i);

	// ====================================================================
	// Address decode
	// ====================================================================
	assign hit_stack = (addr_i[31:20] == `STACK_ADDR_HI);
	assign hit_led   = (addr_i[31:4] == `LED_ADDR_HI);
	assign hit_rand  = (addr_i[31:4] == `RAND_ADDR_HI);
	assign hit_any   = hit_stack || hit_led || hit_rand;

	// Counter starts on the edge where the cycle is first seen
	assign cnt_load_o = (state == IDLE) && strobe && hit_any;
	assign cnt_val_o  = hit_stack ? wait_count_t'(`STACK_WAIT) :
	                    hit_any   ? wait_count_t'(`IO_WAIT) : '0;

	// Last wait cycle so the write lands on the following edge
	assign cyc_end    = (state == WAIT) && cnt_done_i;
	assign stack_we_o = cyc_end && sel_stack && !rw_i;
	assign led_we_o   = cyc_end && sel_led && !rw_i;
	assign rand_we_o  = cyc_end && sel_rand && !rw_i;

	always_comb begin
		rd_mux = '0;
		if (sel_stack)
			rd_mux = stack_rdata_i;
		else if (sel_led)
			rd_mux = led_rdata_i;
		else if (sel_rand)
			rd_mux = rand_rdata_i;
	end

	// ====================================================================
	// Cycle sequencing
	// ====================================================================
	always_ff @(posedge cpu_clk) begin
		if (!rst_n_i) begin
			state     <= IDLE;
			dtack_n_o <= 1'b1;
			berr_n_o  <= 1'b1;
			sel_stack <= 1'b0;
			sel_led   <= 1'b0;
			sel_rand  <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (strobe) begin
						// Target stays latched for the whole cycle
						sel_stack <= hit_stack;
						sel_led   <= hit_led;
						sel_rand  <= hit_rand;
						state     <= hit_any ? WAIT : BERR;
					end
				end
				WAIT: begin
					if (cnt_done_i) begin
						dtack_n_o <= 1'b0;
						state     <= ACK;
					end
				end
				BERR: begin
					berr_n_o <= 1'b0;
					state    <= ACK;
				end
				ACK: begin
					// Response held until the master drops its strobe
					if (!strobe) begin
						dtack_n_o <= 1'b1;
						berr_n_o  <= 1'b1;
						state     <= RELEASE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Read word captured together with dtack
	always_ff @(posedge cpu_clk) begin
		if (cyc_end && rw_i)
			rdata_o <= rd_mux;
	end

	a_resp_exclusive: assert property (@(posedge cpu_clk) disable iff (!rst_n_i)
		!(!dtack_n_o && !berr_n_o))
		else $error("dtack_n_o and berr_n_o low together");

	a_we_onehot: assert property (@(posedge cpu_clk) disable iff (!rst_n_i)
		$onehot0({stack_we_o, led_we_o, rand_we_o}))
		else $error("more than one write strobe high");

endmodule

// ==== rtl/led_switch_port.sv ====
// LEDs follow the low byte only; switches are sampled as-is with no debounce
`timescale 1ns/10ps

module led_switch_port (
	input  logic                    cpu_clk,
	input  logic                    rst_n_i,
	input  logic                    we_i,
	input  logic                    lds_n_i,
	input  m68k_bus_pkg::bus_data_t wdata_i,
	input  logic [7:0]              sw_i,
	output logic [7:0]              led_o,
	output m68k_bus_pkg::bus_data_t rdata_o
);
	import m68k_bus_pkg::*;

	// ====================================================================
	// LED register
	// ====================================================================

	// Upper-lane-only write leaves the LEDs alone
	always_ff @(posedge cpu_clk) begin
		if (!rst_n_i) begin
			led_o <= '0;
		end else if (we_i && !lds_n_i) begin
			led_o <= wdata_i[7:0];
		end
	end

	// ====================================================================
	// Switch read-back
	// ====================================================================
	assign rdata_o = bus_data_t'({8'h00, sw_i});

endmodule

// ==== rtl/lfsr_random.sv ====
// Registers 0/1 are the low/high state halves and 2 steps on write; a zero seed loads 1
`timescale 1ns/10ps
`include "m68k_bus_settings.svh"

module lfsr_random (
	input  logic                    cpu_clk,
	input  logic                    rst_n_i,
	input  logic                    we_i,
	input  logic [1:0]              reg_sel_i,
	input  m68k_bus_pkg::bus_data_t wdata_i,
	output m68k_bus_pkg::bus_data_t rdata_o
);
	import m68k_bus_pkg::*;

	lfsr_state_t state_q;
	lfsr_state_t stepped;
	lfsr_state_t seed_word;

	// Galois step applies the taps when a one falls out of bit 0
	assign stepped = {1'b0, state_q[31:1]} ^
	                 (state_q[0] ? lfsr_state_t'(`LFSR_TAPS) : '0);

	// Seed write replaces one half and keeps the other
	assign seed_word = reg_sel_i[0] ? {wdata_i, state_q[15:0]} :
	                                  {state_q[31:16], wdata_i};

	always_ff @(posedge cpu_clk) begin
		if (!rst_n_i) begin
			state_q <= 32'd1;
		end else if (we_i) begin
			case (reg_sel_i)
				2'd0, 2'd1: begin
					// All-zero would lock the generator up
					state_q <= (seed_word == '0) ? 32'd1 : seed_word;
				end
				2'd2: begin
					state_q <= stepped;
				end
				default: begin
					state_q <= state_q;
				end
			endcase
		end
	end

	always_comb begin
		case (reg_sel_i)
			2'd0:    rdata_o = state_q[15:0];
			2'd1:    rdata_o = state_q[31:16];
			default: rdata_o = '0;
		endcase
	end

	a_state_nonzero: assert property (@(posedge cpu_clk) disable iff (!rst_n_i)
		state_q != '0)
		else $error("generator state reached zero");

endmodule

// ==== rtl/stack_ram.sv ====
// Byte-lane RAM with registered read; read data lags the address by one edge
`timescale 1ns/10ps
`include "m68k_bus_settings.svh"

module stack_ram (
	input  logic                    cpu_clk,
	input  logic [`STACK_AW-1:0]    word_addr_i,
	input  logic                    we_i,
	input  logic                    uds_n_i,
	input  logic                    lds_n_i,
	input  m68k_bus_pkg::bus_data_t wdata_i,
	output m68k_bus_pkg::bus_data_t rdata_o
);
	import m68k_bus_pkg::*;

	localparam int unsigned DEPTH = 1 << `STACK_AW;

	bus_data_t mem [0:DEPTH-1];

	// ====================================================================
	// Write port with one enable per lane
	// ====================================================================
	always_ff @(posedge cpu_clk) begin
		if (we_i && !uds_n_i)
			mem[word_addr_i][15:8] <= wdata_i[15:8];
		if (we_i && !lds_n_i)
			mem[word_addr_i][7:0] <= wdata_i[7:0];
	end

	// Read returns the old word on a write edge
	always_ff @(posedge cpu_clk) begin
		rdata_o <= mem[word_addr_i];
	end

	a_addr_known: assert property (@(posedge cpu_clk)
		we_i |-> !$isunknown(word_addr_i))
		else $error("stack write with unknown address");

endmodule

// ==== rtl/wait_state_counter.sv ====
// Counts down to zero and holds there; a load always restarts the count
`timescale 1ns/10ps

module wait_state_counter (
	input  logic                      cpu_clk,
	input  logic                      rst_n_i,
	input  logic                      load_i,
	input  m68k_bus_pkg::wait_count_t load_val_i,
	output logic                      done_o
);
	import m68k_bus_pkg::*;

	wait_count_t count;

	always_ff @(posedge cpu_clk) begin
		if (!rst_n_i) begin
			count <= '0;
		end else if (load_i) begin
			count <= load_val_i;
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// Done only once the count has run out and no new cycle is starting
	assign done_o = (count == '0) && !load_i;

	a_no_done_on_load: assert property (@(posedge cpu_clk) disable iff (!rst_n_i)
		load_i |-> !done_o)
		else $error("done_o high during a load");

endmodule

// ==== rtl/m68k_bus_pkg.sv ====
// Shared bus types; the widths assume a 68000-style 16-bit data bus and a flat 32-bit address
package m68k_bus_pkg;

	// ====================================================================
	// Bus widths
	// ====================================================================

	// CPU byte address with bit 0 unused by word accesses
	typedef logic [31:0] bus_addr_t;

	// One data bus word with the upper lane in 15..8
	typedef logic [15:0] bus_data_t;

	// ====================================================================
	// Cycle timing and targets
	// ====================================================================

	// Wait states per cycle up to the slowest target
	typedef logic [2:0] wait_count_t;

	// Full state of the pseudo-random generator
	typedef logic [31:0] lfsr_state_t;

	// ====================================================================
	// Bus cycle controller
	// ====================================================================

	// WAIT counts wait states, ACK holds the response until release,
	// BERR is the one cycle before the bus error response goes out
	typedef enum logic [2:0] {
		IDLE    = 3'd0,
		WAIT    = 3'd1,
		ACK     = 3'd2,
		BERR    = 3'd3,
		RELEASE = 3'd4
	} bus_state_e;

endpackage

// ==== rtl/m68k_bus_settings.svh ====
// Address map and timing constants; the windows must not overlap and wait counts must fit 3 bits
`ifndef M68K_BUS_SETTINGS_SVH
`define M68K_BUS_SETTINGS_SVH

// ====================================================================
// Address map
// ====================================================================

// Stack window on address bits 31..20
`define STACK_ADDR_HI 12'hFF4

// LED/switch port on address bits 31..4
`define LED_ADDR_HI 28'hFFDC060

// Random generator on address bits 31..4
`define RAND_ADDR_HI 28'hFFDC0C0

// ====================================================================
// Wait states and sizes
// ====================================================================

`define STACK_WAIT 3
`define IO_WAIT 1

// Word address bits of the stack, which aliases inside its 1 MB window
`define STACK_AW 10

// Galois feedback mask applied after the right shift
`define LFSR_TAPS 32'h80200003

`endif
